//--- Makefile
VERILATOR ?= verilator
TOP       ?= tb_snes_mcu_cmd
FILELIST  ?= sources.f
OBJ_DIR   ?= obj_dir
LOG       ?= sim.log
VFLAGS    ?= --binary --timing --assert
RUN_ARGS  ?= +verilator+error+limit+100

SRCS      := $(shell grep -v '^+' $(FILELIST))
SIM_BIN   := $(OBJ_DIR)/V$(TOP)
FAIL_MSG  := TEST FAILED
PASS_MSG  := TEST PASSED

.PHONY: all compile run clean

all: run

compile: $(SIM_BIN)

$(SIM_BIN): $(FILELIST) $(SRCS)
	$(VERILATOR) $(VFLAGS) --top-module $(TOP) -Mdir $(OBJ_DIR) -f $(FILELIST)

run: compile
	-./$(SIM_BIN) $(RUN_ARGS) > $(LOG) 2>&1
	@cat $(LOG)
	@if grep -q "$(FAIL_MSG)" $(LOG); then echo "simulation failed, see $(LOG)"; exit 1; fi
	@if ! grep -q "$(PASS_MSG)" $(LOG); then echo "no pass line in $(LOG)"; exit 1; fi

clean:
	rm -rf $(OBJ_DIR) $(LOG)

//--- bench/snes_mcu_cmd_asserts.sv
`timescale 1ns/1ns

module snes_mcu_cmd_asserts (
  input logic clk,
  input logic rst_n,
  input logic mem_rrq,
  input logic mem_wrq
);

  int fail_cnt = 0;

  // one access at a time, so never both kinds
  assert property (@(posedge clk) disable iff (!rst_n) !(mem_rrq && mem_wrq))
    else begin
      fail_cnt++;
      $error("mem_rrq and mem_wrq high in the same cycle");
    end

  // requests are single-cycle pulses
  assert property (@(posedge clk) disable iff (!rst_n) mem_rrq |=> !mem_rrq)
    else begin
      fail_cnt++;
      $error("mem_rrq held for more than one cycle");
    end

  assert property (@(posedge clk) disable iff (!rst_n) mem_wrq |=> !mem_wrq)
    else begin
      fail_cnt++;
      $error("mem_wrq held for more than one cycle");
    end

  assert property (@(posedge clk) !rst_n |-> !(mem_rrq || mem_wrq))
    else begin
      fail_cnt++;
      $error("memory request raised during reset");
    end

endmodule

bind mem_access snes_mcu_cmd_asserts asserts_i (
  .clk     (clk),
  .rst_n   (rst_n),
  .mem_rrq (mem_rrq),
  .mem_wrq (mem_wrq)
);

//--- bench/tb_snes_mcu_cmd.sv
`timescale 1ns/1ns

module tb_snes_mcu_cmd;

  import mcu_cmd_pkg::*;

  localparam int N_CMDS      = 400;
  // command byte plus up to five parameters
  localparam int MAX_STROBES = 6;
  // strobe, request latency, worst responder delay, ready hold, settle, gap
  localparam int STROBE_CYC  = 2 + 2 + 6 + 3 + 2 + 4;
  localparam int MAX_CYCLES  = N_CMDS * (MAX_STROBES * STROBE_CYC + 3) + 100;

  logic    clk;
  logic    rst_n;
  logic    cmd_valid;
  byte_t   cmd_data;
  logic    param_valid;
  byte_t   param_data;
  logic    mem_rdy;
  byte_t   mem_rdata;
  mapper_t mapper;
  addr_t   rom_mask;
  addr_t   saveram_mask;
  byte_t   feature_bits;
  addr_t   mem_addr;
  logic    mem_rrq;
  logic    mem_wrq;
  byte_t   mem_wdata;
  byte_t   spi_rdata;

  int seed;
  int errors;
  int checks;
  int cycles;

  // memory responder
  logic [7:0]  mem_array [64];
  int          resp_delay;
  int          req_cnt;
  logic [23:0] req_addr;
  logic        req_write;
  logic [7:0]  req_wdata;

  // reference model
  logic [2:0]  m_mapper;
  logic [23:0] m_rom;
  logic [23:0] m_sram;
  logic [7:0]  m_feat;
  logic [23:0] m_addr;
  logic [7:0]  m_spi;
  logic [7:0]  m_mem [64];
  int          m_req_cnt;
  logic        m_req;
  logic [23:0] m_req_addr;

  snes_mcu_cmd snes_mcu_cmd_i (
    .clk          (clk),
    .rst_n        (rst_n),
    .cmd_valid    (cmd_valid),
    .cmd_data     (cmd_data),
    .param_valid  (param_valid),
    .param_data   (param_data),
    .mem_rdy      (mem_rdy),
    .mem_rdata    (mem_rdata),
    .mapper       (mapper),
    .rom_mask     (rom_mask),
    .saveram_mask (saveram_mask),
    .feature_bits (feature_bits),
    .mem_addr     (mem_addr),
    .mem_rrq      (mem_rrq),
    .mem_wrq      (mem_wrq),
    .mem_wdata    (mem_wdata),
    .spi_rdata    (spi_rdata)
  );

  always #5 clk = ~clk;

  // initial memory contents, every address bit counts
  function automatic logic [7:0] fill_byte(input logic [5:0] a);
    return {a, 2'b10} ^ {2'b00, a};
  endfunction

  task automatic check(input string name, input logic [31:0] got, input logic [31:0] exp);
    checks++;
    if (got !== exp) begin
      errors++;
      $display("ERR t=%0t %s got 0x%0h expected 0x%0h", $time, name, got, exp);
    end
  endtask

  task automatic check_outputs();
    check("mapper", 32'(mapper), 32'(m_mapper));
    check("rom_mask", 32'(rom_mask), 32'(m_rom));
    check("saveram_mask", 32'(saveram_mask), 32'(m_sram));
    check("feature_bits", 32'(feature_bits), 32'(m_feat));
    check("mem_addr", 32'(mem_addr), 32'(m_addr));
    check("spi_rdata", 32'(spi_rdata), 32'(m_spi));
    check("request count", 32'(req_cnt), 32'(m_req_cnt));
  endtask

  // one host strobe, held for a single cycle
  task automatic send_byte(input logic is_cmd, input logic [7:0] b);
    @(posedge clk);
    if (is_cmd) begin
      cmd_valid <= 1'b1;
      cmd_data  <= b;
    end else begin
      param_valid <= 1'b1;
      param_data  <= b;
    end
    @(posedge clk);
    cmd_valid   <= 1'b0;
    param_valid <= 1'b0;
  endtask

  // ready high then low, plus one cycle for the readback register
  task automatic wait_access();
    while (mem_rdy !== 1'b1) begin
      @(negedge clk);
    end
    while (mem_rdy !== 1'b0) begin
      @(negedge clk);
    end
    @(negedge clk);
  endtask

  // bytes 2..4 of a 24-bit field, MSB first
  function automatic logic [23:0] merge_byte(input logic [23:0] cur, input int idx,
                                             input logic [7:0] b);
    logic [23:0] res;
    res = cur;
    case (idx)
      2: res[23:16] = b;
      3: res[15:8]  = b;
      4: res[7:0]   = b;
      default: res = cur;
    endcase
    return res;
  endfunction

  task automatic model_strobe(input logic [7:0] cmd, input int idx, input logic [7:0] b);
    m_req = 1'b0;
    if (cmd == 8'hED) begin
      if (idx == 2) begin
        m_feat = b;
      end
    end else if (cmd == 8'hF0) begin
      m_spi = 8'hA5;
    end else if (cmd == 8'hFF) begin
      m_spi = b;
    end else begin
      case (cmd[7:4])
        4'h3: begin
          if (idx == 1) begin
            m_mapper = b[2:0];
          end
        end
        4'h1: m_rom  = merge_byte(m_rom, idx, b);
        4'h2: m_sram = merge_byte(m_sram, idx, b);
        4'h0: begin
          // first address byte wipes the lower 16 bits
          if (idx == 2) begin
            m_addr = {b, 16'h0000};
          end else begin
            m_addr = merge_byte(m_addr, idx, b);
          end
        end
        4'h8, 4'h9: begin
          // reads on every strobe, writes only on data bytes
          if (!cmd[4] || idx >= 2) begin
            m_req      = 1'b1;
            m_req_addr = m_addr;
            m_req_cnt++;
            if (cmd[4]) begin
              m_mem[m_addr[5:0]] = b;
            end else begin
              m_spi = m_mem[m_addr[5:0]];
            end
            if (cmd[3]) begin
              m_addr = m_addr + 24'd1;
            end
          end
        end
        default: m_req = 1'b0;
      endcase
    end
  endtask

  task automatic run_command();
    logic [31:0] r;
    logic [7:0]  cmd;
    logic [7:0]  b;
    int          kind;
    int          nparam;
    int          gap;
    int          idx;
    r      = $random(seed);
    kind   = int'(r[15:8]) % 9;
    nparam = int'(r[18:16]) % 6;
    case (kind)
      0: cmd = {4'h3, r[3:0]};
      1: cmd = {4'h1, r[3:0]};
      2: cmd = {4'h2, r[3:0]};
      3: cmd = {4'h0, r[3:0]};
      4: cmd = {4'h8, r[3:0]};
      5: cmd = {4'h9, r[3:0]};
      6: cmd = 8'hED;
      7: cmd = 8'hF0;
      default: cmd = 8'hFF;
    endcase
    for (idx = 1; idx <= nparam + 1; idx++) begin
      r          = $random(seed);
      b          = (idx == 1) ? cmd : r[7:0];
      gap        = 1 + int'(r[9:8]);
      resp_delay = 2 + int'(r[14:10]) % 5;
      send_byte(idx == 1, b);
      model_strobe(cmd, idx, b);
      if (m_req) begin
        wait_access();
        check("request count", 32'(req_cnt), 32'(m_req_cnt));
        check("request address", 32'(req_addr), 32'(m_req_addr));
        check("request is write", 32'(req_write), 32'(cmd[4]));
        if (cmd[4]) begin
          check("mem_wdata", 32'(req_wdata), 32'(b));
        end
        check("mem_addr", 32'(mem_addr), 32'(m_addr));
        check("spi_rdata", 32'(spi_rdata), 32'(m_spi));
      end else if (cmd == 8'hF0 || cmd == 8'hFF) begin
        @(negedge clk);
        @(negedge clk);
        check("spi_rdata", 32'(spi_rdata), 32'(m_spi));
      end
      repeat (gap - 1) @(posedge clk);
    end
    // two cycles after the last strobe
    @(negedge clk);
    @(negedge clk);
    check_outputs();
  endtask

  //////////////////////////////
  // memory responder
  //////////////////////////////
  initial begin
    logic [6:0] i;
    mem_rdy   = 1'b0;
    mem_rdata = 8'h00;
    req_cnt   = 0;
    for (i = 7'd0; i < 7'd64; i = i + 7'd1) begin
      mem_array[i[5:0]] = fill_byte(i[5:0]);
    end
    forever begin
      @(negedge clk);
      if (mem_rrq || mem_wrq) begin
        req_cnt++;
        req_addr  = mem_addr;
        req_write = mem_wrq;
        req_wdata = mem_wdata;
        if (mem_wrq) begin
          mem_array[mem_addr[5:0]] = mem_wdata;
        end
        repeat (resp_delay) @(posedge clk);
        mem_rdata <= mem_array[req_addr[5:0]];
        mem_rdy   <= 1'b1;
        repeat (3) @(posedge clk);
        mem_rdy   <= 1'b0;
      end
    end
  end

  initial begin
    cycles = 0;
    while (cycles < MAX_CYCLES) begin
      @(posedge clk);
      cycles++;
    end
    $display("timeout after %0d cycles, the command sequence never finished", cycles);
    $display("TEST FAILED");
    $finish;
  end

  //////////////////////////////
  // main sequence
  //////////////////////////////
  initial begin
    logic [6:0] i;
    seed        = 32'head4;
    errors      = 0;
    checks      = 0;
    clk         = 1'b0;
    rst_n       = 1'b0;
    cmd_valid   = 1'b0;
    cmd_data    = 8'h00;
    param_valid = 1'b0;
    param_data  = 8'h00;
    resp_delay  = 2;
    m_mapper    = 3'd1;
    m_rom       = 24'hFFFFFF;
    m_sram      = 24'hFFFFFF;
    m_feat      = 8'h00;
    m_addr      = 24'h000000;
    m_spi       = 8'h00;
    m_req_cnt   = 0;
    for (i = 7'd0; i < 7'd64; i = i + 7'd1) begin
      m_mem[i[5:0]] = fill_byte(i[5:0]);
    end
    repeat (4) @(posedge clk);
    rst_n <= 1'b1;
    @(negedge clk);
    check_outputs();
    check("mem_rrq", 32'(mem_rrq), 32'd0);
    check("mem_wrq", 32'(mem_wrq), 32'd0);
    repeat (N_CMDS) run_command();
    repeat (4) @(negedge clk);
    for (i = 7'd0; i < 7'd64; i = i + 7'd1) begin
      check($sformatf("mem_array[%0d]", i), 32'(mem_array[i[5:0]]), 32'(m_mem[i[5:0]]));
    end
    if (snes_mcu_cmd_i.mem_access_i.asserts_i.fail_cnt != 0) begin
      errors++;
      $display("memory request protocol broken %0d times",
               snes_mcu_cmd_i.mem_access_i.asserts_i.fail_cnt);
    end
    $display("errors: %0d, checks: %0d", errors, checks);
    if (errors == 0) begin
      $display("TEST PASSED");
    end else begin
      $display("TEST FAILED");
    end
    $finish;
  end

endmodule

//--- sources.f
src/mcu_cmd_pkg.sv
src/cmd_decode.sv
src/config_regs.sv
src/mem_access.sv
src/readback_mux.sv
src/snes_mcu_cmd.sv
bench/snes_mcu_cmd_asserts.sv
bench/tb_snes_mcu_cmd.sv

//--- src/cmd_decode.sv
`timescale 1ns/1ns

module cmd_decode (
  input  logic                   clk,
  input  logic                   rst_n,
  input  logic                   cmd_valid,
  input  mcu_cmd_pkg::byte_t     cmd_data,
  input  logic                   param_valid,
  input  mcu_cmd_pkg::byte_t     param_data,
  output logic                   op_valid,
  output mcu_cmd_pkg::cmd_op_t   op,
  output mcu_cmd_pkg::byte_idx_t byte_idx,
  output mcu_cmd_pkg::byte_t     op_data,
  output logic                   auto_inc
);

  import mcu_cmd_pkg::*;

  byte_t     cmd_reg;
  byte_idx_t byte_cnt;
  byte_t     cmd_sel;
  byte_idx_t idx_next;
  logic      strobe;

  // map a command byte onto one operation
  function automatic cmd_op_t classify(byte_t cmd);
    cmd_op_t res;
    res = OP_NONE;
    if (cmd == CMD_FEATURES) begin
      res = OP_FEATURES;
    end else if (cmd == CMD_ID) begin
      res = OP_ID;
    end else if (cmd == CMD_ECHO) begin
      res = OP_ECHO;
    end else begin
      case (cmd[7:4])
        CMD_SET_ADDR:  res = OP_SET_ADDR;
        CMD_ROM_MASK:  res = OP_ROM_MASK;
        CMD_SRAM_MASK: res = OP_SRAM_MASK;
        CMD_MAPPER:    res = OP_MAPPER;
        CMD_MEM_READ:  res = OP_MEM_READ;
        CMD_MEM_WRITE: res = OP_MEM_WRITE;
        default:       res = OP_NONE;
      endcase
    end
    return res;
  endfunction

  assign strobe = cmd_valid | param_valid;

  // a command strobe decodes its own byte, parameters use the latched one
  assign cmd_sel = cmd_valid ? cmd_data : cmd_reg;

  // command byte is 1, each parameter counts up and sticks at 15
  always_comb begin
    if (cmd_valid) begin
      idx_next = IDX_CMD;
    end else if (byte_cnt == '1) begin
      idx_next = byte_cnt;
    end else begin
      idx_next = byte_cnt + 1'b1;
    end
  end

  //////////////////////////////
  // command latch and counter
  //////////////////////////////
  always_ff @(posedge clk or negedge rst_n) begin
    if (!rst_n) begin
      cmd_reg  <= CMD_IDLE;
      byte_cnt <= '0;
    end else begin
      if (cmd_valid) begin
        cmd_reg <= cmd_data;
      end
      if (strobe) begin
        byte_cnt <= idx_next;
      end
    end
  end

  //////////////////////////////
  // registered operation
  //////////////////////////////
  always_ff @(posedge clk or negedge rst_n) begin
    if (!rst_n) begin
      op_valid <= 1'b0;
      op       <= OP_NONE;
      byte_idx <= '0;
    end else begin
      op_valid <= strobe;
      if (strobe) begin
        op       <= classify(cmd_sel);
        byte_idx <= idx_next;
      end
    end
  end

  // payload of the strobe
  always_ff @(posedge clk) begin
    if (strobe) begin
      op_data  <= cmd_valid ? cmd_data : param_data;
      // bit 3 selects address auto-increment on read and write
      auto_inc <= cmd_sel[3];
    end
  end

endmodule

//--- src/config_regs.sv
`timescale 1ns/1ns

module config_regs (
  input  logic                   clk,
  input  logic                   rst_n,
  input  logic                   op_valid,
  input  mcu_cmd_pkg::cmd_op_t   op,
  input  mcu_cmd_pkg::byte_idx_t byte_idx,
  input  mcu_cmd_pkg::byte_t     op_data,
  output mcu_cmd_pkg::mapper_t   mapper,
  output mcu_cmd_pkg::addr_t     rom_mask,
  output mcu_cmd_pkg::addr_t     saveram_mask,
  output mcu_cmd_pkg::byte_t     feature_bits
);

  import mcu_cmd_pkg::*;

  logic ld_mapper;
  logic ld_rom;
  logic ld_sram;
  logic ld_feat;

  // drop one byte of a 24-bit mask into place, MSB first
  function automatic addr_t place_byte(addr_t cur, byte_idx_t idx, byte_t b);
    addr_t res;
    res = cur;
    case (idx)
      IDX_HI:  res[23:16] = b;
      IDX_MID: res[15:8]  = b;
      IDX_LO:  res[7:0]   = b;
      default: res = cur;
    endcase
    return res;
  endfunction

  // mapper comes with the command byte itself
  assign ld_mapper = op_valid && (op == OP_MAPPER) && (byte_idx == IDX_CMD);
  // mask bytes outside 2..4 fall through place_byte unchanged
  assign ld_rom    = op_valid && (op == OP_ROM_MASK);
  assign ld_sram   = op_valid && (op == OP_SRAM_MASK);
  assign ld_feat   = op_valid && (op == OP_FEATURES) && (byte_idx == IDX_HI);

  //////////////////////////////
  // configuration registers
  //////////////////////////////
  always_ff @(posedge clk or negedge rst_n) begin
    if (!rst_n) begin
      mapper       <= MAPPER_RESET;
      rom_mask     <= MASK_RESET;
      saveram_mask <= MASK_RESET;
      feature_bits <= FEATURE_RESET;
    end else begin
      if (ld_mapper) begin
        mapper <= op_data[2:0];
      end
      if (ld_rom) begin
        rom_mask <= place_byte(rom_mask, byte_idx, op_data);
      end
      if (ld_sram) begin
        saveram_mask <= place_byte(saveram_mask, byte_idx, op_data);
      end
      if (ld_feat) begin
        feature_bits <= op_data;
      end
    end
  end

endmodule

//--- src/mcu_cmd_pkg.sv
package mcu_cmd_pkg;

  //////////////////////////////
  // widths and types
  //////////////////////////////
  localparam int ADDR_W = 24;

  typedef logic [7:0]        byte_t;
  typedef logic [ADDR_W-1:0] addr_t;
  typedef logic [2:0]        mapper_t;
  // position of a byte inside a command, saturates at 15
  typedef logic [3:0]        byte_idx_t;

  typedef enum logic [3:0] {
    OP_NONE,
    OP_MAPPER,
    OP_ROM_MASK,
    OP_SRAM_MASK,
    OP_SET_ADDR,
    OP_MEM_READ,
    OP_MEM_WRITE,
    OP_FEATURES,
    OP_ID,
    OP_ECHO
  } cmd_op_t;

  //////////////////////////////
  // command encodings
  //////////////////////////////
  // upper nibble groups
  localparam logic [3:0] CMD_SET_ADDR  = 4'h0;
  localparam logic [3:0] CMD_ROM_MASK  = 4'h1;
  localparam logic [3:0] CMD_SRAM_MASK = 4'h2;
  localparam logic [3:0] CMD_MAPPER    = 4'h3;
  localparam logic [3:0] CMD_MEM_READ  = 4'h8;
  localparam logic [3:0] CMD_MEM_WRITE = 4'h9;
  // full byte commands
  localparam byte_t CMD_FEATURES = 8'hED;
  localparam byte_t CMD_ID       = 8'hF0;
  localparam byte_t CMD_ECHO     = 8'hFF;
  // latched command before the first command strobe, decodes to nothing
  localparam byte_t CMD_IDLE     = 8'hFE;

  // byte positions: command, then parameters MSB first
  localparam byte_idx_t IDX_CMD = 4'd1;
  localparam byte_idx_t IDX_HI  = 4'd2;
  localparam byte_idx_t IDX_MID = 4'd3;
  localparam byte_idx_t IDX_LO  = 4'd4;

  //////////////////////////////
  // constants and reset values
  //////////////////////////////
  localparam byte_t   ID_BYTE       = 8'hA5;
  localparam mapper_t MAPPER_RESET  = 3'd1;
  localparam addr_t   MASK_RESET    = {ADDR_W{1'b1}};
  localparam byte_t   FEATURE_RESET = 8'h00;

endpackage

//--- src/mem_access.sv
`timescale 1ns/1ns

module mem_access (
  input  logic                   clk,
  input  logic                   rst_n,
  input  logic                   op_valid,
  input  mcu_cmd_pkg::cmd_op_t   op,
  input  mcu_cmd_pkg::byte_idx_t byte_idx,
  input  mcu_cmd_pkg::byte_t     op_data,
  input  logic                   auto_inc,
  input  logic                   mem_rdy,
  input  mcu_cmd_pkg::byte_t     mem_rdata,
  output mcu_cmd_pkg::addr_t     mem_addr,
  output logic                   mem_rrq,
  output logic                   mem_wrq,
  output mcu_cmd_pkg::byte_t     mem_wdata,
  output logic                   rd_valid,
  output mcu_cmd_pkg::byte_t     rd_data
);

  import mcu_cmd_pkg::*;

  logic [2:0] rdy_sync;
  logic       rdy_rise;
  logic       rd_hit;
  logic       wr_hit;
  logic       addr_hit;
  logic       acc_busy;
  logic       acc_rd;
  logic       acc_inc;
  logic       acc_done;

  // every strobe of a read command reads, a write needs a data byte
  assign rd_hit   = op_valid && (op == OP_MEM_READ);
  assign wr_hit   = op_valid && (op == OP_MEM_WRITE) && (byte_idx >= IDX_HI);
  assign addr_hit = op_valid && (op == OP_SET_ADDR);

  //////////////////////////////
  // ready synchronizer
  //////////////////////////////
  // two flops into the clock domain, third one for the edge
  always_ff @(posedge clk or negedge rst_n) begin
    if (!rst_n) begin
      rdy_sync <= '0;
    end else begin
      rdy_sync <= {rdy_sync[1:0], mem_rdy};
    end
  end

  assign rdy_rise = rdy_sync[1] & ~rdy_sync[2];
  // end of the one outstanding access
  assign acc_done = rdy_rise & acc_busy;

  //////////////////////////////
  // requests
  //////////////////////////////
  always_ff @(posedge clk or negedge rst_n) begin
    if (!rst_n) begin
      mem_rrq  <= 1'b0;
      mem_wrq  <= 1'b0;
      acc_busy <= 1'b0;
      acc_rd   <= 1'b0;
      acc_inc  <= 1'b0;
      rd_valid <= 1'b0;
    end else begin
      mem_rrq  <= rd_hit;
      mem_wrq  <= wr_hit;
      rd_valid <= acc_done & acc_rd;
      if (rd_hit || wr_hit) begin
        acc_busy <= 1'b1;
        acc_rd   <= rd_hit;
        acc_inc  <= auto_inc;
      end else if (acc_done) begin
        acc_busy <= 1'b0;
      end
    end
  end

  // write data goes out alongside mem_wrq
  always_ff @(posedge clk) begin
    if (wr_hit) begin
      mem_wdata <= op_data;
    end
  end

  // read data sampled while mem_rdy is still held
  always_ff @(posedge clk) begin
    if (acc_done && acc_rd) begin
      rd_data <= mem_rdata;
    end
  end

  //////////////////////////////
  // address pointer
  //////////////////////////////
  always_ff @(posedge clk or negedge rst_n) begin
    if (!rst_n) begin
      mem_addr <= '0;
    end else if (addr_hit) begin
      case (byte_idx)
        // top byte clears the rest
        IDX_HI:  mem_addr <= {op_data, 16'h0000};
        IDX_MID: mem_addr[15:8] <= op_data;
        IDX_LO:  mem_addr[7:0] <= op_data;
        default: mem_addr <= mem_addr;
      endcase
    end else if (acc_done && acc_inc) begin
      mem_addr <= mem_addr + 1'b1;
    end
  end

endmodule

//--- src/readback_mux.sv
`timescale 1ns/1ns

module readback_mux (
  input  logic                 clk,
  input  logic                 rst_n,
  input  logic                 op_valid,
  input  mcu_cmd_pkg::cmd_op_t op,
  input  mcu_cmd_pkg::byte_t   op_data,
  input  logic                 rd_valid,
  input  mcu_cmd_pkg::byte_t   rd_data,
  output mcu_cmd_pkg::byte_t   spi_rdata
);

  import mcu_cmd_pkg::*;

  logic  load;
  byte_t next_byte;

  // pick the source for the byte shifted back to the host
  always_comb begin
    load      = 1'b0;
    next_byte = spi_rdata;
    if (rd_valid) begin
      // memory byte from a finished read
      load      = 1'b1;
      next_byte = rd_data;
    end else if (op_valid) begin
      case (op)
        OP_ID: begin
          load      = 1'b1;
          next_byte = ID_BYTE;
        end
        OP_ECHO: begin
          // loopback of the strobe's own byte
          load      = 1'b1;
          next_byte = op_data;
        end
        default: begin
          load      = 1'b0;
          next_byte = spi_rdata;
        end
      endcase
    end
  end

  //////////////////////////////
  // host readback register
  //////////////////////////////
  always_ff @(posedge clk or negedge rst_n) begin
    if (!rst_n) begin
      spi_rdata <= '0;
    end else if (load) begin
      spi_rdata <= next_byte;
    end
  end

endmodule

//--- src/snes_mcu_cmd.sv
`timescale 1ns/1ns

module snes_mcu_cmd (
  input  logic                 clk,
  input  logic                 rst_n,
  input  logic                 cmd_valid,
  input  mcu_cmd_pkg::byte_t   cmd_data,
  input  logic                 param_valid,
  input  mcu_cmd_pkg::byte_t   param_data,
  input  logic                 mem_rdy,
  input  mcu_cmd_pkg::byte_t   mem_rdata,
  output mcu_cmd_pkg::mapper_t mapper,
  output mcu_cmd_pkg::addr_t   rom_mask,
  output mcu_cmd_pkg::addr_t   saveram_mask,
  output mcu_cmd_pkg::byte_t   feature_bits,
  output mcu_cmd_pkg::addr_t   mem_addr,
  output logic                 mem_rrq,
  output logic                 mem_wrq,
  output mcu_cmd_pkg::byte_t   mem_wdata,
  output mcu_cmd_pkg::byte_t   spi_rdata
);

  import mcu_cmd_pkg::*;

  // decoded strobe
  logic      op_valid;
  cmd_op_t   op;
  byte_idx_t byte_idx;
  byte_t     op_data;
  logic      auto_inc;

  // finished read
  logic      rd_valid;
  byte_t     rd_data;

  //////////////////////////////
  // decode
  //////////////////////////////
  cmd_decode cmd_decode_i (
    .clk         (clk),
    .rst_n       (rst_n),
    .cmd_valid   (cmd_valid),
    .cmd_data    (cmd_data),
    .param_valid (param_valid),
    .param_data  (param_data),
    .op_valid    (op_valid),
    .op          (op),
    .byte_idx    (byte_idx),
    .op_data     (op_data),
    .auto_inc    (auto_inc)
  );

  //////////////////////////////
  // execute
  //////////////////////////////
  config_regs config_regs_i (
    .clk          (clk),
    .rst_n        (rst_n),
    .op_valid     (op_valid),
    .op           (op),
    .byte_idx     (byte_idx),
    .op_data      (op_data),
    .mapper       (mapper),
    .rom_mask     (rom_mask),
    .saveram_mask (saveram_mask),
    .feature_bits (feature_bits)
  );

  mem_access mem_access_i (
    .clk       (clk),
    .rst_n     (rst_n),
    .op_valid  (op_valid),
    .op        (op),
    .byte_idx  (byte_idx),
    .op_data   (op_data),
    .auto_inc  (auto_inc),
    .mem_rdy   (mem_rdy),
    .mem_rdata (mem_rdata),
    .mem_addr  (mem_addr),
    .mem_rrq   (mem_rrq),
    .mem_wrq   (mem_wrq),
    .mem_wdata (mem_wdata),
    .rd_valid  (rd_valid),
    .rd_data   (rd_data)
  );

  // result back to the host
  readback_mux readback_mux_i (
    .clk       (clk),
    .rst_n     (rst_n),
    .op_valid  (op_valid),
    .op        (op),
    .op_data   (op_data),
    .rd_valid  (rd_valid),
    .rd_data   (rd_data),
    .spi_rdata (spi_rdata)
  );

endmodule
